/* audio_cfg_pkg.sv */
`default_nettype none

package audio_cfg_pkg;

    // Field widths
    localparam int REG_ADDR_W = 7;
    localparam int REG_DATA_W = 9;
    localparam int FRAME_BITS = 28;
    localparam int NUM_REGS   = 7;

    typedef logic [REG_ADDR_W-1:0]            reg_addr_t;   // Codec register address
    typedef logic [REG_DATA_W-1:0]            reg_data_t;   // Nine bit register value
    typedef logic [REG_ADDR_W+REG_DATA_W-1:0] reg_word_t;   // Address above data
    typedef logic [FRAME_BITS-1:0]            i2c_frame_t;  // MSB goes out first
    typedef logic [2:0]                       reg_idx_t;
    typedef logic [4:0]                       bit_cnt_t;

    // Device address byte with the write bit
    localparam logic [7:0] CODEC_ADDR = 8'h34;

    localparam reg_idx_t LAST_REG_IDX = reg_idx_t'(NUM_REGS - 1);
    localparam bit_cnt_t FRAME_END    = bit_cnt_t'(FRAME_BITS);

    // Acknowledge positions, counted from the first bit on the wire
    localparam bit_cnt_t ACK_SLOT_0 = 5'd8;
    localparam bit_cnt_t ACK_SLOT_1 = 5'd17;
    localparam bit_cnt_t ACK_SLOT_2 = 5'd26;

    // Power-up writes in send order
    localparam reg_word_t INIT_TABLE [NUM_REGS] = '{
        {reg_addr_t'(7'h0F), reg_data_t'(9'h000)},  // Reset
        {reg_addr_t'(7'h04), reg_data_t'(9'h015)},  // Analogue path
        {reg_addr_t'(7'h05), reg_data_t'(9'h000)},  // Digital path
        {reg_addr_t'(7'h06), reg_data_t'(9'h000)},  // Power-down
        {reg_addr_t'(7'h07), reg_data_t'(9'h042)},  // Interface format
        {reg_addr_t'(7'h08), reg_data_t'(9'h019)},  // Sampling control
        {reg_addr_t'(7'h09), reg_data_t'(9'h001)}   // Active control
    };

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_WAIT,
        SEQ_DONE
    } seq_state_t;

    // Bit engine states
    typedef enum logic [2:0] {
        SH_IDLE,
        SH_SETUP,   // Start condition
        SH_HIGH,
        SH_LOW,
        SH_STOP,
        SH_GAP
    } shift_state_t;

endpackage

`default_nettype wire

/* codec_reg_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module codec_reg_sequencer (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_start,
    input  logic                      i_frame_done,
    output audio_cfg_pkg::i2c_frame_t o_frame,
    output logic                      o_frame_load,
    output audio_cfg_pkg::reg_idx_t   o_reg_idx,
    output logic                      o_run_start,
    output logic                      o_seq_done
);

    audio_cfg_pkg::seq_state_t state_r, state_w;
    audio_cfg_pkg::reg_idx_t   idx_r, idx_w;
    audio_cfg_pkg::i2c_frame_t frame_r, frame_w;

    logic start_d_r;        // Previous i_start
    logic start_edge_r;     // Registered rising edge
    logic load_r, load_w;
    logic run_start_r, run_start_w;
    logic done_r, done_w;

    // Address byte and the two entry bytes each end in a released slot
    function automatic audio_cfg_pkg::i2c_frame_t build_frame(
        input audio_cfg_pkg::reg_idx_t idx
    );
        audio_cfg_pkg::reg_word_t word;
        word = audio_cfg_pkg::INIT_TABLE[idx];
        return {audio_cfg_pkg::CODEC_ADDR, 1'b1,
                word[15:8], 1'b1,
                word[7:0], 1'b1,
                1'b0};
    endfunction

    assign o_frame      = frame_r;
    assign o_frame_load = load_r;
    assign o_reg_idx    = idx_r;
    assign o_run_start  = run_start_r;
    assign o_seq_done   = done_r;

    always_comb begin
        state_w     = state_r;
        idx_w       = idx_r;
        frame_w     = frame_r;
        load_w      = 1'b0;
        run_start_w = 1'b0;
        done_w      = 1'b0;
        case (state_r)
            audio_cfg_pkg::SEQ_IDLE: begin
                if (start_edge_r) begin     // Edges in other states are dropped
                    state_w     = audio_cfg_pkg::SEQ_LOAD;
                    idx_w       = '0;
                    frame_w     = build_frame('0);
                    load_w      = 1'b1;
                    run_start_w = 1'b1;
                end
            end
            audio_cfg_pkg::SEQ_LOAD: begin
                state_w = audio_cfg_pkg::SEQ_WAIT;
            end
            audio_cfg_pkg::SEQ_WAIT: begin
                if (i_frame_done) begin
                    if (idx_r == audio_cfg_pkg::LAST_REG_IDX) begin
                        state_w = audio_cfg_pkg::SEQ_DONE;
                        done_w  = 1'b1;
                    end else begin
                        state_w = audio_cfg_pkg::SEQ_LOAD;
                        idx_w   = idx_r + 3'd1;
                        frame_w = build_frame(idx_r + 3'd1);
                        load_w  = 1'b1;
                    end
                end
            end
            audio_cfg_pkg::SEQ_DONE: begin
                state_w = audio_cfg_pkg::SEQ_IDLE;
            end
            default: begin
                state_w = audio_cfg_pkg::SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r      <= audio_cfg_pkg::SEQ_IDLE;
            idx_r        <= '0;
            start_d_r    <= 1'b0;
            start_edge_r <= 1'b0;
            load_r       <= 1'b0;
            run_start_r  <= 1'b0;
            done_r       <= 1'b0;
        end else begin
            state_r      <= state_w;
            idx_r        <= idx_w;
            start_d_r    <= i_start;
            start_edge_r <= i_start & ~start_d_r;
            load_r       <= load_w;
            run_start_r  <= run_start_w;
            done_r       <= done_w;
        end
    end

    always_ff @(posedge i_clk) begin
        frame_r <= frame_w;
    end

    // A finished frame always finds the sequencer waiting for it
    a_done_in_wait: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        i_frame_done |-> (state_r == audio_cfg_pkg::SEQ_WAIT)
    );

endmodule

`default_nettype wire

/* i2c_frame_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_frame_shifter (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  audio_cfg_pkg::i2c_frame_t i_frame,
    input  logic                      i_frame_load,
    output logic                      o_sclk,
    output logic                      o_sdat,
    output logic                      o_oen,
    output logic                      o_scl_rise,
    output logic                      o_frame_done
);

    audio_cfg_pkg::shift_state_t state_r, state_w;
    audio_cfg_pkg::i2c_frame_t   shift_r, shift_w;
    audio_cfg_pkg::bit_cnt_t     cnt_r, cnt_w;      // Next bit to drive
    audio_cfg_pkg::bit_cnt_t     bit_on_bus;

    logic scl_r, scl_w;
    logic sda_r, sda_w;
    logic oen_r, oen_w;
    logic rise_r, rise_w;
    logic done_r, done_w;
    logic ack_slot;

    assign ack_slot = (cnt_r == audio_cfg_pkg::ACK_SLOT_0) ||
                      (cnt_r == audio_cfg_pkg::ACK_SLOT_1) ||
                      (cnt_r == audio_cfg_pkg::ACK_SLOT_2);

    // Counter has already moved past the bit being shown
    assign bit_on_bus = cnt_r - 5'd1;

    assign o_sclk       = scl_r;
    assign o_sdat       = sda_r;
    assign o_oen        = oen_r;
    assign o_scl_rise   = rise_r;
    assign o_frame_done = done_r;

    always_comb begin
        state_w = state_r;
        shift_w = shift_r;
        cnt_w   = cnt_r;
        scl_w   = scl_r;
        sda_w   = sda_r;
        oen_w   = oen_r;
        rise_w  = 1'b0;
        done_w  = 1'b0;
        case (state_r)
            audio_cfg_pkg::SH_IDLE: begin
                if (i_frame_load) begin
                    shift_w = i_frame;
                    cnt_w   = '0;
                    state_w = audio_cfg_pkg::SH_SETUP;
                end
            end
            audio_cfg_pkg::SH_SETUP: begin
                sda_w   = 1'b0;             // SDA falls under a high SCL
                state_w = audio_cfg_pkg::SH_LOW;
            end
            audio_cfg_pkg::SH_LOW: begin
                scl_w   = 1'b0;
                sda_w   = shift_r[audio_cfg_pkg::FRAME_BITS-1];
                shift_w = shift_r << 1;
                oen_w   = ~ack_slot;        // Let the codec drive the slot
                cnt_w   = cnt_r + 5'd1;
                state_w = audio_cfg_pkg::SH_HIGH;
            end
            audio_cfg_pkg::SH_HIGH: begin
                scl_w   = 1'b1;
                rise_w  = 1'b1;
                if (cnt_r == audio_cfg_pkg::FRAME_END) begin
                    state_w = audio_cfg_pkg::SH_STOP;
                end else begin
                    state_w = audio_cfg_pkg::SH_LOW;
                end
            end
            audio_cfg_pkg::SH_STOP: begin
                sda_w   = 1'b1;             // Trailing low bit rises to the stop
                state_w = audio_cfg_pkg::SH_GAP;
            end
            audio_cfg_pkg::SH_GAP: begin
                done_w  = 1'b1;
                state_w = audio_cfg_pkg::SH_IDLE;
            end
            default: begin
                state_w = audio_cfg_pkg::SH_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r <= audio_cfg_pkg::SH_IDLE;
            cnt_r   <= '0;
            scl_r   <= 1'b1;            // Bus idles high
            sda_r   <= 1'b1;
            oen_r   <= 1'b1;
            rise_r  <= 1'b0;
            done_r  <= 1'b0;
        end else begin
            state_r <= state_w;
            cnt_r   <= cnt_w;
            scl_r   <= scl_w;
            sda_r   <= sda_w;
            oen_r   <= oen_w;
            rise_r  <= rise_w;
            done_r  <= done_w;
        end
    end

    // Frame payload
    always_ff @(posedge i_clk) begin
        shift_r <= shift_w;
    end

    // Data only moves under a high clock for start and stop
    a_sda_stable_high: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        (o_sclk && $past(o_sclk) && (o_sdat != $past(o_sdat))) |->
            ($past(state_r) == audio_cfg_pkg::SH_SETUP ||
             $past(state_r) == audio_cfg_pkg::SH_STOP)
    );

    a_oen_at_ack: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        !o_oen |->
            ((state_r == audio_cfg_pkg::SH_HIGH || state_r == audio_cfg_pkg::SH_LOW) &&
             (bit_on_bus == audio_cfg_pkg::ACK_SLOT_0 ||
              bit_on_bus == audio_cfg_pkg::ACK_SLOT_1 ||
              bit_on_bus == audio_cfg_pkg::ACK_SLOT_2))
    );

endmodule

`default_nettype wire

/* i2c_ack_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_ack_monitor (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_run_start,
    input  logic                    i_frame_load,
    input  audio_cfg_pkg::reg_idx_t i_reg_idx,
    input  logic                    i_oen,
    input  logic                    i_scl_rise,
    input  logic                    i_sdat_in,
    input  logic                    i_seq_done,
    output logic                    o_nack,
    output audio_cfg_pkg::reg_idx_t o_nack_reg,
    output logic                    o_finished
);

    audio_cfg_pkg::reg_idx_t cur_idx_r;     // Register now on the bus
    audio_cfg_pkg::reg_idx_t nack_reg_r;

    logic       in_frame_r;
    logic [1:0] ack_cnt_r;                  // Slots seen in this frame
    logic       nack_r;
    logic       finished_r;
    logic       ack_sample;

    // Codec owns SDA in this clock high phase
    assign ack_sample = in_frame_r & i_scl_rise & ~i_oen;

    assign o_nack     = nack_r;
    assign o_nack_reg = nack_reg_r;
    assign o_finished = finished_r;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            in_frame_r <= 1'b0;
            ack_cnt_r  <= '0;
            nack_r     <= 1'b0;
            nack_reg_r <= '0;
            finished_r <= 1'b0;
        end else begin
            if (i_run_start) begin
                nack_r     <= 1'b0;
                nack_reg_r <= '0;
                finished_r <= 1'b0;
            end else begin
                if (ack_sample && i_sdat_in && !nack_r) begin
                    nack_r     <= 1'b1;     // First refusal wins
                    nack_reg_r <= cur_idx_r;
                end
                if (i_seq_done) begin
                    finished_r <= 1'b1;
                end
            end

            if (i_frame_load) begin
                in_frame_r <= 1'b1;
                ack_cnt_r  <= '0;
            end else if (ack_sample) begin
                ack_cnt_r <= ack_cnt_r + 2'd1;
                if (ack_cnt_r == 2'd2) begin
                    in_frame_r <= 1'b0;     // Third slot closes the frame
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_frame_load) begin
            cur_idx_r <= i_reg_idx;
        end
    end

    // Sequencer must wait out every frame before finishing
    a_done_outside_frame: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        i_seq_done |-> !in_frame_r
    );

endmodule

`default_nettype wire

/* codec_i2c_init_top.sv */
`timescale 1ns/1ps
`default_nettype none

module codec_i2c_init_top (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  logic                    i_sdat_in,
    output logic                    o_sclk,
    output logic                    o_sdat,
    output logic                    o_oen,
    output logic                    o_finished,
    output logic                    o_nack,
    output audio_cfg_pkg::reg_idx_t o_nack_reg
);

    audio_cfg_pkg::i2c_frame_t frame;
    audio_cfg_pkg::reg_idx_t   reg_idx;

    logic frame_load;
    logic frame_done;
    logic run_start;
    logic seq_done;
    logic scl_rise;

    // Walks the table and builds frames
    codec_reg_sequencer codec_reg_sequencer_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_frame_done (frame_done),
        .o_frame      (frame),
        .o_frame_load (frame_load),
        .o_reg_idx    (reg_idx),
        .o_run_start  (run_start),
        .o_seq_done   (seq_done)
    );

    i2c_frame_shifter i2c_frame_shifter_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_frame      (frame),
        .i_frame_load (frame_load),
        .o_sclk       (o_sclk),
        .o_sdat       (o_sdat),
        .o_oen        (o_oen),
        .o_scl_rise   (scl_rise),
        .o_frame_done (frame_done)
    );

    // Judges the codec answers
    i2c_ack_monitor i2c_ack_monitor_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_run_start  (run_start),
        .i_frame_load (frame_load),
        .i_reg_idx    (reg_idx),
        .i_oen        (o_oen),
        .i_scl_rise   (scl_rise),
        .i_sdat_in    (i_sdat_in),
        .i_seq_done   (seq_done),
        .o_nack       (o_nack),
        .o_nack_reg   (o_nack_reg),
        .o_finished   (o_finished)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int HALF_PERIOD  = 4;    // 8 ns clock
    localparam int RESET_CYCLES = 3;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Reset level is high, released on a falling edge
    initial begin
        o_rst_n = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_codec_i2c_init.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_codec_i2c_init;

    localparam int NUM_RUNS   = 12;
    localparam int NUM_FRAMES = 7;
    localparam int FRAME_LEN  = 28;
    localparam int NUM_SLOTS  = NUM_FRAMES * 3;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * (NUM_FRAMES * 64 + 64) + 200;

    logic clk;
    logic rst_n;
    logic start;
    logic sdat_in = 1'b1;          // Codec side idles released
    logic sclk;
    logic sdat;
    logic oen;
    logic finished;
    logic nack;
    audio_cfg_pkg::reg_idx_t nack_reg;

    // Bus decoder state
    logic prev_scl = 1'b1;
    logic prev_sda = 1'b1;
    logic in_frame = 1'b0;
    int   bits = 0;
    int   pos;
    int   total_frames = 0;
    int   run_base = 0;             // Frame count when the current run began
    audio_cfg_pkg::i2c_frame_t shreg;

    logic        refuse_plan [NUM_SLOTS];   // Codec answer per slot, high refuses
    logic [31:0] rng_state = 32'd24;
    logic [4:0]  slot_idx;
    int          slot;

    tb_clk_gen tb_clk_gen_inst (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    codec_i2c_init_top codec_i2c_init_top_inst (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_start    (start),
        .i_sdat_in  (sdat_in),
        .o_sclk     (sclk),
        .o_sdat     (sdat),
        .o_oen      (oen),
        .o_finished (finished),
        .o_nack     (nack),
        .o_nack_reg (nack_reg)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Codec register writes, 7 bit address above 9 bit value
    function automatic audio_cfg_pkg::i2c_frame_t expected_frame(input int idx);
        logic [15:0] word;
        case (idx)
            0:       word = {7'h0F, 9'h000};    // Reset
            1:       word = {7'h04, 9'h015};    // Analogue path
            2:       word = {7'h05, 9'h000};
            3:       word = {7'h06, 9'h000};    // Power-down
            4:       word = {7'h07, 9'h042};
            5:       word = {7'h08, 9'h019};    // Sampling
            default: word = {7'h09, 9'h001};    // Active
        endcase
        return {8'h34, 1'b1, word[15:8], 1'b1, word[7:0], 1'b1, 1'b0};
    endfunction

    function automatic logic is_ack_pos(input int p);
        return (p == 8) || (p == 17) || (p == 26);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_frame(input audio_cfg_pkg::i2c_frame_t got,
                               input audio_cfg_pkg::i2c_frame_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_idx(input audio_cfg_pkg::reg_idx_t got,
                             input audio_cfg_pkg::reg_idx_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    // Bus decoder, sees the values held through the cycle that just ended
    always @(posedge clk) begin
        if (!rst_n) begin
            if (prev_scl && sclk && (sdat != prev_sda)) begin
                if (!sdat) begin                // Start condition
                    if (in_frame) begin
                        abort_run("A start condition appeared in the middle of a frame");
                    end
                    if (total_frames - run_base >= NUM_FRAMES) begin
                        abort_run("The DUT began more than seven frames in one run");
                    end
                    check_flag(finished, 1'b0, "o_finished at a frame start");
                    if (total_frames == run_base) begin
                        check_flag(nack, 1'b0, "o_nack at the first frame of a run");
                    end
                    in_frame     = 1'b1;
                    bits         = 0;
                    shreg        = '0;
                    total_frames = total_frames + 1;
                end else begin                  // Stop condition
                    if (!in_frame || bits != FRAME_LEN) begin
                        abort_run("A stop condition came before the 28 bits of a frame");
                    end
                    check_frame(shreg, expected_frame(total_frames - run_base - 1),
                                "decoded frame");
                    in_frame = 1'b0;
                end
            end
            if (!prev_scl && sclk) begin
                if (!in_frame || bits >= FRAME_LEN) begin
                    abort_run("SCL pulsed outside the 28 bits of a frame");
                end
                bits  = bits + 1;
                shreg = {shreg[FRAME_LEN-2:0], sdat};
                check_flag(oen, !is_ack_pos(bits - 1), "o_oen during a frame bit");
            end
            if (!oen) begin
                pos = sclk ? bits - 1 : bits;   // Bit now on the bus
                if (!in_frame || !is_ack_pos(pos)) begin
                    abort_run("o_oen went low outside an acknowledge slot");
                end
            end
            prev_scl = sclk;
            prev_sda = sdat;
        end
    end

    // Codec answer while the DUT releases SDA
    always @(negedge clk) begin
        if (!oen && !sclk) begin
            slot     = (bits == 8) ? 0 : (bits == 17) ? 1 : 2;
            slot_idx = 5'((total_frames - run_base - 1) * 3 + slot);
            sdat_in  = refuse_plan[slot_idx];
        end else if (oen) begin
            sdat_in = 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("Timeout: the runs did not complete within the cycle limit");
    end

    initial begin
        int run;
        int gap;
        int width;
        int delay;
        int s;
        logic exp_nack;
        audio_cfg_pkg::reg_idx_t exp_idx;

        start = 1'b0;
        exp_nack = 1'b0;
        exp_idx = '0;
        wait (!rst_n);
        repeat (2) @(negedge clk);
        check_flag(sclk, 1'b1, "o_sclk after reset");
        check_flag(sdat, 1'b1, "o_sdat after reset");
        check_flag(oen, 1'b1, "o_oen after reset");
        check_flag(finished, 1'b0, "o_finished after reset");
        check_flag(nack, 1'b0, "o_nack after reset");

        for (run = 0; run < NUM_RUNS; run++) begin
            gap = 2 + int'(next_random() & 32'd15);
            repeat (gap) begin
                @(negedge clk);
                if (run > 0) begin
                    check_flag(finished, 1'b1, "o_finished between runs");
                    check_flag(nack, exp_nack, "o_nack between runs");
                end
            end
            if (total_frames != run * NUM_FRAMES) begin
                abort_run("Frames appeared while no run was active");
            end

            // About one slot in eight is refused
            exp_nack = 1'b0;
            exp_idx  = '0;
            for (s = 0; s < NUM_SLOTS; s++) begin
                refuse_plan[5'(s)] = ((next_random() & 32'd7) == 32'd0);
                if (refuse_plan[5'(s)] && !exp_nack) begin
                    exp_nack = 1'b1;
                    exp_idx  = audio_cfg_pkg::reg_idx_t'(s / 3);
                end
            end
            run_base = total_frames;

            width = 1 + int'(next_random() & 32'd3);
            start = 1'b1;
            repeat (width) @(negedge clk);
            start = 1'b0;
            while (total_frames == run_base) @(negedge clk);

            if ((next_random() & 32'd1) != 32'd0) begin
                delay = int'(next_random() & 32'd255);
                width = 1 + int'(next_random() & 32'd3);
                @(negedge clk);
                repeat (delay) @(negedge clk);
                start = 1'b1;                   // Should be ignored, run is busy
                repeat (width) @(negedge clk);
                start = 1'b0;
            end

            while (!finished) @(negedge clk);
            if (total_frames - run_base != NUM_FRAMES || in_frame) begin
                abort_run("o_finished rose before seven complete frames were sent");
            end
            check_flag(nack, exp_nack, "o_nack after the run");
            if (exp_nack) begin
                check_idx(nack_reg, exp_idx, "o_nack_reg after the run");
            end
        end

        repeat (20) @(negedge clk);
        if (total_frames != NUM_RUNS * NUM_FRAMES) begin
            abort_run("Frames appeared after the last run had finished");
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* codec_i2c_init_top.f */
audio_cfg_pkg.sv
codec_reg_sequencer.sv
i2c_frame_shifter.sv
i2c_ack_monitor.sv
codec_i2c_init_top.sv
tb_clk_gen.sv
tb_codec_i2c_init.sv

/* Makefile */
TOP = tb_codec_i2c_init

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f codec_i2c_init_top.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	verilator --lint-only -Wall --timing -f codec_i2c_init_top.f --top-module codec_i2c_init_top

clean:
	rm -rf obj_dir
